/* dv/queue_states_vectors.svh */
/* Stimulus and expected values for the queue state testbench, included
   into its module body and applied row by row. */
`ifndef QUEUE_STATES_VECTORS_SVH
`define QUEUE_STATES_VECTORS_SVH

localparam logic [2:0] OP_OCC_ADD = 3'd0;
localparam logic [2:0] OP_OCC_RD  = 3'd1;
localparam logic [2:0] OP_TAIL_WR = 3'd2;
localparam logic [2:0] OP_TAIL_RD = 3'd3;
localparam logic [2:0] OP_DQ      = 3'd4;
localparam logic [2:0] OP_DQ_LAST = 3'd5;
localparam logic [2:0] OP_EMPTY   = 3'd6;
localparam logic [2:0] OP_BP_ADD  = 3'd7;

// Columns: op, queue, reps, data, expected value, expected response
// reps sweeps queues on a read, repeats a dequeue on one queue
typedef struct packed {
    logic [2:0] op;
    queue_id_t  queue;
    logic [5:0] reps;
    a4l_data_t  data;
    a4l_data_t  expv;
    a4l_resp_t  resp;
} vec_t;

localparam int NUM_VECS = 27;

localparam vec_t VECS [NUM_VECS] = '{
    '{OP_OCC_RD,  5'd0,  6'd16, 32'd0,      32'd0,      RESP_OKAY},
    '{OP_TAIL_RD, 5'd0,  6'd16, 32'd0,      32'd0,      RESP_OKAY},
    '{OP_EMPTY,   5'd0,  6'd1,  32'd0,      32'hffff,   RESP_OKAY},
    // Two packets into queue 5
    '{OP_OCC_ADD, 5'd5,  6'd1,  32'd1500,   32'd0,      RESP_OKAY},
    '{OP_OCC_ADD, 5'd5,  6'd1,  32'd64,     32'd0,      RESP_OKAY},
    '{OP_OCC_RD,  5'd5,  6'd1,  32'd0,      32'd1564,   RESP_OKAY},
    '{OP_EMPTY,   5'd0,  6'd1,  32'd0,      32'hffdf,   RESP_OKAY},
    // 24 full words out, then the 28 byte tail
    '{OP_DQ,      5'd5,  6'd24, 32'd64,     32'd0,      RESP_OKAY},
    '{OP_OCC_RD,  5'd5,  6'd1,  32'd0,      32'd28,     RESP_OKAY},
    '{OP_EMPTY,   5'd0,  6'd1,  32'd0,      32'hffdf,   RESP_OKAY},
    '{OP_DQ_LAST, 5'd5,  6'd1,  32'd28,     32'd0,      RESP_OKAY},
    '{OP_OCC_RD,  5'd5,  6'd1,  32'd0,      32'd0,      RESP_OKAY},
    '{OP_EMPTY,   5'd0,  6'd1,  32'd0,      32'hffff,   RESP_OKAY},
    // Malloc of page 17 at offset 10, then offset 40 with a stray page
    '{OP_TAIL_WR, 5'd3,  6'd1,  32'h844a,   32'd0,      RESP_OKAY},
    '{OP_TAIL_RD, 5'd3,  6'd1,  32'd0,      32'h844a,   RESP_OKAY},
    '{OP_TAIL_WR, 5'd3,  6'd1,  32'h18e8,   32'd0,      RESP_OKAY},
    '{OP_TAIL_RD, 5'd3,  6'd1,  32'd0,      32'h8468,   RESP_OKAY},
    // Queue 20 is out of range and aliases queue 4 in the low bits
    '{OP_OCC_ADD, 5'd20, 6'd1,  32'd500,    32'd0,      RESP_SLVERR},
    '{OP_OCC_RD,  5'd20, 6'd1,  32'd0,      32'd0,      RESP_SLVERR},
    '{OP_TAIL_WR, 5'd20, 6'd1,  32'h844a,   32'd0,      RESP_SLVERR},
    '{OP_TAIL_RD, 5'd20, 6'd1,  32'd0,      32'd0,      RESP_SLVERR},
    '{OP_OCC_RD,  5'd4,  6'd1,  32'd0,      32'd0,      RESP_OKAY},
    '{OP_TAIL_RD, 5'd4,  6'd1,  32'd0,      32'd0,      RESP_OKAY},
    '{OP_EMPTY,   5'd0,  6'd1,  32'd0,      32'hffff,   RESP_OKAY},
    '{OP_BP_ADD,  5'd6,  6'd1,  32'd100,    32'd0,      RESP_OKAY},
    '{OP_OCC_RD,  5'd6,  6'd1,  32'd0,      32'd200,    RESP_OKAY},
    '{OP_EMPTY,   5'd0,  6'd1,  32'd0,      32'hffbf,   RESP_OKAY}
};

`endif

/* dv/queue_states_tb.sv */
/* Testbench for the queue state block. Applies the stimulus table over both
   AXI4-Lite ports and the dequeue input and checks every result. */
`timescale 1ns/1ps

module queue_states_tb;

    import queue_geom_pkg::*;
    import queue_regs_pkg::*;

    localparam int NUM_EGR_PORTS  = 4;
    localparam int NUM_QUEUES     = NUM_EGR_PORTS * QUEUES_PER_PORT;
    localparam int TIMEOUT_CYCLES = 50;

    // Handshake signals a wait can watch
    localparam int SIG_AWREADY = 0;
    localparam int SIG_BVALID  = 1;
    localparam int SIG_ARREADY = 2;
    localparam int SIG_RVALID  = 3;

    `include "queue_states_vectors.svh"

    logic core_clk_ifc = 1'b0;
    logic arst_n;

    // Bus master side, steered to one port by use_tail
    logic       use_tail;
    logic       awvalid_m, wvalid_m, arvalid_m, bready_m, rready_m;
    a4l_addr_t  awaddr_m, araddr_m;
    a4l_data_t  wdata_m;
    logic       dq_valid, dq_last;
    queue_id_t  dq_queue;
    word_blen_t dq_blen;

    logic      occ_awready, occ_wready, occ_bvalid, occ_arready, occ_rvalid;
    logic      tail_awready, tail_wready, tail_bvalid, tail_arready, tail_rvalid;
    a4l_resp_t occ_bresp, occ_rresp, tail_bresp, tail_rresp;
    a4l_data_t occ_rdata, tail_rdata;
    logic [NUM_QUEUES-1:0] queue_empty;

    int          value_errs;
    int          resp_errs;
    int          timeout_errs;
    logic [31:0] lfsr_state;

    always #5 core_clk_ifc = ~core_clk_ifc;

    queue_states_top #(.NUM_EGR_PORTS(NUM_EGR_PORTS)) dut0 (
        .core_clk_ifc(core_clk_ifc), .arst_n(arst_n),
        .occ_awvalid(awvalid_m & ~use_tail), .occ_awready(occ_awready), .occ_awaddr(awaddr_m),
        .occ_wvalid(wvalid_m & ~use_tail), .occ_wready(occ_wready), .occ_wdata(wdata_m),
        .occ_bvalid(occ_bvalid), .occ_bready(bready_m & ~use_tail), .occ_bresp(occ_bresp),
        .occ_arvalid(arvalid_m & ~use_tail), .occ_arready(occ_arready), .occ_araddr(araddr_m),
        .occ_rvalid(occ_rvalid), .occ_rready(rready_m & ~use_tail),
        .occ_rdata(occ_rdata), .occ_rresp(occ_rresp),
        .tail_awvalid(awvalid_m & use_tail), .tail_awready(tail_awready),
        .tail_awaddr(awaddr_m),
        .tail_wvalid(wvalid_m & use_tail), .tail_wready(tail_wready), .tail_wdata(wdata_m),
        .tail_bvalid(tail_bvalid), .tail_bready(bready_m & use_tail), .tail_bresp(tail_bresp),
        .tail_arvalid(arvalid_m & use_tail), .tail_arready(tail_arready),
        .tail_araddr(araddr_m),
        .tail_rvalid(tail_rvalid), .tail_rready(rready_m & use_tail),
        .tail_rdata(tail_rdata), .tail_rresp(tail_rresp),
        .dq_valid(dq_valid), .dq_queue(dq_queue), .dq_blen(dq_blen), .dq_last(dq_last),
        .queue_empty(queue_empty)
    );

    ////////////////////////////////////////////////////////////
    // Random bits and run end
    ////////////////////////////////////////////////////////////

    // Galois form, taps 32 22 2 1
    function automatic logic [31:0] galois_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    task automatic random_bits(input int n, output logic [7:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[6:0], lfsr_state[0]};
            lfsr_state = galois_step(lfsr_state);
        end
    endtask

    task automatic end_run();
        $display("Errors: %0d value, %0d response, %0d timeout",
                 value_errs, resp_errs, timeout_errs);
        if (value_errs + resp_errs + timeout_errs == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    endtask

    ////////////////////////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////////////////////////

    task automatic check_occupancy(input string what, input occupancy_t got,
                                   input occupancy_t exp);
        if (got !== exp) begin
            value_errs++;
            $display("mismatch %s: got %h expected %h", what, got, exp);
        end
    endtask

    task automatic check_tail(input string what, input tail_word_u got,
                              input tail_word_u exp);
        if (got !== exp) begin
            value_errs++;
            $display("mismatch %s: got %h expected %h", what, got, exp);
        end
    endtask

    task automatic check_resp(input string what, input a4l_resp_t got, input a4l_resp_t exp);
        if (got !== exp) begin
            resp_errs++;
            $display("mismatch %s: got %h expected %h", what, got, exp);
        end
    endtask

    task automatic check_empty(input logic [NUM_QUEUES-1:0] got,
                               input logic [NUM_QUEUES-1:0] exp);
        if (got !== exp) begin
            value_errs++;
            $display("mismatch queue_empty: got %h expected %h", got, exp);
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            value_errs++;
            $display("mismatch %s: got %h expected %h", what, got, exp);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Bus and dequeue drivers
    ////////////////////////////////////////////////////////////

    function automatic string port_name();
        if (use_tail) begin
            return "tail";
        end
        return "occ";
    endfunction

    function automatic logic level(input int sig);
        case (sig)
            SIG_AWREADY: return use_tail ? tail_awready : occ_awready;
            SIG_BVALID:  return use_tail ? tail_bvalid : occ_bvalid;
            SIG_ARREADY: return use_tail ? tail_arready : occ_arready;
            default:     return use_tail ? tail_rvalid : occ_rvalid;
        endcase
    endfunction

    // Returns on the falling edge where the signal is seen high
    task automatic wait_until(input int sig, input string name);
        int n;
        n = 0;
        while (!level(sig) && n < TIMEOUT_CYCLES) begin
            @(negedge core_clk_ifc);
            n++;
        end
        if (!level(sig)) begin
            timeout_errs++;
            $display("Timed out waiting for %s_%s", port_name(), name);
            end_run();
        end
    endtask

    task automatic take_write_resp(input a4l_resp_t exp);
        wait_until(SIG_BVALID, "bvalid");
        check_resp($sformatf("%s_bresp", port_name()),
                   use_tail ? tail_bresp : occ_bresp, exp);
        bready_m = 1'b1;
        @(negedge core_clk_ifc);
        bready_m = 1'b0;
    endtask

    task automatic bus_write(input logic tail, input queue_id_t q, input a4l_data_t d,
                             input a4l_resp_t exp);
        use_tail  = tail;
        awaddr_m  = {1'b0, q, 2'b00};
        wdata_m   = d;
        awvalid_m = 1'b1;
        wvalid_m  = 1'b1;
        wait_until(SIG_AWREADY, "awready");
        check_flag($sformatf("%s_wready", port_name()),
                   use_tail ? tail_wready : occ_wready, 1'b1);
        @(negedge core_clk_ifc);
        awvalid_m = 1'b0;
        wvalid_m  = 1'b0;
        take_write_resp(exp);
    endtask

    task automatic bus_read(input logic tail, input queue_id_t q, output a4l_data_t d,
                            output a4l_resp_t r);
        use_tail  = tail;
        araddr_m  = {1'b0, q, 2'b00};
        arvalid_m = 1'b1;
        wait_until(SIG_ARREADY, "arready");
        @(negedge core_clk_ifc);
        arvalid_m = 1'b0;
        wait_until(SIG_RVALID, "rvalid");
        d = tail ? tail_rdata : occ_rdata;
        r = tail ? tail_rresp : occ_rresp;
        rready_m = 1'b1;
        @(negedge core_clk_ifc);
        rready_m = 1'b0;
    endtask

    // Two adds, the second offered while the first response is held back
    task automatic write_with_backpressure(input queue_id_t q, input a4l_data_t d);
        logic [7:0] bits;
        int         hold;
        random_bits(3, bits);
        hold      = int'(bits) % 7 + 1;
        use_tail  = 1'b0;
        awaddr_m  = {1'b0, q, 2'b00};
        wdata_m   = d;
        awvalid_m = 1'b1;
        wvalid_m  = 1'b1;
        wait_until(SIG_AWREADY, "awready");
        check_flag("occ_wready", occ_wready, 1'b1);
        @(negedge core_clk_ifc);
        repeat (hold) begin
            check_flag("occ_bvalid", occ_bvalid, 1'b1);
            check_flag("occ_awready", occ_awready, 1'b0);
            check_flag("occ_wready", occ_wready, 1'b0);
            @(negedge core_clk_ifc);
        end
        take_write_resp(RESP_OKAY);
        wait_until(SIG_AWREADY, "awready");
        check_flag("occ_wready", occ_wready, 1'b1);
        @(negedge core_clk_ifc);
        awvalid_m = 1'b0;
        wvalid_m  = 1'b0;
        take_write_resp(RESP_OKAY);
    endtask

    task automatic dequeue(input queue_id_t q, input word_blen_t blen, input logic last);
        dq_valid = 1'b1;
        dq_queue = q;
        dq_blen  = blen;
        dq_last  = last;
        @(negedge core_clk_ifc);
        dq_valid = 1'b0;
        dq_last  = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        vec_t      v;
        a4l_data_t d;
        a4l_resp_t r;
        queue_id_t q;
        lfsr_state   = 32'h230f_383e;
        value_errs   = 0;
        resp_errs    = 0;
        timeout_errs = 0;
        arst_n       = 1'b0;
        use_tail     = 1'b0;
        awvalid_m    = 1'b0;
        wvalid_m     = 1'b0;
        arvalid_m    = 1'b0;
        bready_m     = 1'b0;
        rready_m     = 1'b0;
        awaddr_m     = '0;
        araddr_m     = '0;
        wdata_m      = '0;
        dq_valid     = 1'b0;
        dq_last      = 1'b0;
        dq_queue     = '0;
        dq_blen      = '0;
        repeat (8) @(posedge core_clk_ifc);
        @(negedge core_clk_ifc);
        arst_n = 1'b1;
        @(negedge core_clk_ifc);

        for (int i = 0; i < NUM_VECS; i++) begin
            v = VECS[i];
            case (v.op)
                OP_OCC_ADD: bus_write(1'b0, v.queue, v.data, v.resp);
                OP_TAIL_WR: bus_write(1'b1, v.queue, v.data, v.resp);
                OP_OCC_RD, OP_TAIL_RD: begin
                    // One row sweeps reps queues upward
                    for (int k = 0; k < int'(v.reps); k++) begin
                        q = v.queue + queue_id_t'(k);
                        bus_read(v.op == OP_TAIL_RD, q, d, r);
                        if (v.op == OP_TAIL_RD) begin
                            check_tail($sformatf("tail_rdata[%0d]", q), d, v.expv);
                        end else begin
                            check_occupancy($sformatf("occ_rdata[%0d]", q), d, v.expv);
                        end
                        check_resp($sformatf("%s_rresp[%0d]", port_name(), q), r, v.resp);
                    end
                end
                OP_DQ, OP_DQ_LAST: begin
                    for (int k = 0; k < int'(v.reps); k++) begin
                        dequeue(v.queue, word_blen_t'(v.data),
                                v.op == OP_DQ_LAST && k == int'(v.reps) - 1);
                    end
                end
                OP_EMPTY:   check_empty(queue_empty, v.expv[NUM_QUEUES-1:0]);
                OP_BP_ADD:  write_with_backpressure(v.queue, v.data);
                default: begin
                    value_errs++;
                    $display("Row %0d holds an unknown operation", i);
                end
            endcase
        end
        end_run();
    end

endmodule

/* hdl/a4l_table_port.sv */
/* AXI4-Lite slave in front of a queue state table. Turns each bus read or
   write into one table access and answers out-of-range queues with SLVERR. */
`timescale 1ns/1ps

module a4l_table_port #(
    parameter int NUM_EGR_PORTS = 4
) (
    input  logic                        core_clk_ifc,
    input  logic                        arst_n,
    input  logic                        awvalid,
    output logic                        awready,
    input  queue_regs_pkg::a4l_addr_t   awaddr,
    input  logic                        wvalid,
    output logic                        wready,
    input  queue_regs_pkg::a4l_data_t   wdata,
    output logic                        bvalid,
    input  logic                        bready,
    output queue_regs_pkg::a4l_resp_t   bresp,
    input  logic                        arvalid,
    output logic                        arready,
    input  queue_regs_pkg::a4l_addr_t   araddr,
    output logic                        rvalid,
    input  logic                        rready,
    output queue_regs_pkg::a4l_data_t   rdata,
    output queue_regs_pkg::a4l_resp_t   rresp,
    table_access_if.port_side           tbl
);

    import queue_geom_pkg::*;
    import queue_regs_pkg::*;

    localparam int NUM_QUEUES = NUM_EGR_PORTS * QUEUES_PER_PORT;

    queue_id_t aw_queue;
    queue_id_t ar_queue;
    logic      aw_ok;
    logic      ar_ok;
    logic      wr_hs;
    logic      rd_hs;
    logic      rd_go;
    logic      wr_go;
    logic      wr_defer;
    logic      wr_pend_q;
    queue_id_t wr_queue_q;
    a4l_data_t wr_data_q;

    assign aw_queue = awaddr[ADDR_QUEUE_MSB:ADDR_QUEUE_LSB];
    assign ar_queue = araddr[ADDR_QUEUE_MSB:ADDR_QUEUE_LSB];
    assign aw_ok    = int'(aw_queue) < NUM_QUEUES;
    assign ar_ok    = int'(ar_queue) < NUM_QUEUES;

    // AW and W are always taken together
    assign wready = awready;
    assign wr_hs  = awvalid & awready & wvalid & wready;
    assign rd_hs  = arvalid & arready;

    //////////////////////////////////////////////////////////////
    // Table arbitration
    //////////////////////////////////////////////////////////////

    // A read wins the table, a colliding write waits one cycle
    assign rd_go    = rd_hs & ar_ok;
    assign wr_defer = wr_hs & aw_ok & rd_go;
    assign wr_go    = (wr_hs & aw_ok & ~rd_go) | wr_pend_q;

    assign tbl.req_valid = rd_go | wr_go;
    assign tbl.req_write = ~rd_go;
    assign tbl.req_queue = rd_go ? ar_queue : (wr_pend_q ? wr_queue_q : aw_queue);
    assign tbl.req_wdata = wr_pend_q ? wr_data_q : wdata;

    //////////////////////////////////////////////////////////////
    // Channel state
    //////////////////////////////////////////////////////////////

    always_ff @(posedge core_clk_ifc or negedge arst_n) begin
        if (!arst_n) begin
            awready   <= 1'b0;
            arready   <= 1'b0;
            bvalid    <= 1'b0;
            rvalid    <= 1'b0;
            bresp     <= RESP_OKAY;
            rresp     <= RESP_OKAY;
            wr_pend_q <= 1'b0;
        end else begin
            // One-cycle ready pulse, held off while a response waits
            awready   <= ~awready & awvalid & wvalid & ~bvalid;
            arready   <= ~arready & arvalid & ~rvalid;
            wr_pend_q <= wr_defer;
            if (wr_hs) begin
                bvalid <= 1'b1;
                bresp  <= aw_ok ? RESP_OKAY : RESP_SLVERR;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
            if (rd_hs) begin
                rvalid <= 1'b1;
                rresp  <= ar_ok ? RESP_OKAY : RESP_SLVERR;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge core_clk_ifc) begin
        if (rd_hs) begin
            rdata <= ar_ok ? tbl.rd_data : '0;
        end
        if (wr_hs) begin
            wr_queue_q <= aw_queue;
            wr_data_q  <= wdata;
        end
    end

    // Held response keeps its code and blocks the next write
    a_bvalid_hold: assert property (@(posedge core_clk_ifc) disable iff (!arst_n)
        bvalid && !bready |=> bvalid && $stable(bresp) && !awready);

endmodule

/* hdl/occupancy_table.sv */
/* Byte occupancy of every queue. Enqueue writes add to a count, dequeue
   notifications take from it, and a registered empty flag follows each count. */
`timescale 1ns/1ps

module occupancy_table #(
    parameter int NUM_EGR_PORTS = 4
) (
    input  logic                       core_clk_ifc,
    input  logic                       arst_n,
    table_access_if.table_side         tbl,
    input  logic                       dq_valid,
    input  queue_geom_pkg::queue_id_t  dq_queue,
    input  queue_geom_pkg::word_blen_t dq_blen,
    output logic [NUM_EGR_PORTS*queue_geom_pkg::QUEUES_PER_PORT-1:0] queue_empty
);

    import queue_geom_pkg::*;

    localparam int NUM_QUEUES = NUM_EGR_PORTS * QUEUES_PER_PORT;

    occupancy_t cnt_q [NUM_QUEUES];
    occupancy_t cnt_d [NUM_QUEUES];
    occupancy_t enq_blen;
    occupancy_t dq_avail;
    logic       enq;

    // Bus write carries the enqueued byte length
    assign enq      = tbl.req_valid & tbl.req_write;
    assign enq_blen = tbl.req_wdata;

    //////////////////////////////////////////////////////////////
    // Next counts and read mux
    //////////////////////////////////////////////////////////////

    always_comb begin
        tbl.rd_data = '0;
        dq_avail    = '0;
        for (int q = 0; q < NUM_QUEUES; q++) begin
            cnt_d[q] = cnt_q[q];
            // Add and subtract merge when both land on one queue
            if (enq && tbl.req_queue == queue_id_t'(q)) begin
                cnt_d[q] = cnt_d[q] + enq_blen;
            end
            if (dq_valid && dq_queue == queue_id_t'(q)) begin
                cnt_d[q] = cnt_d[q] - occupancy_t'(dq_blen);
            end
            if (tbl.req_queue == queue_id_t'(q)) begin
                tbl.rd_data = cnt_q[q];
            end
            // Bytes a dequeue may take, same-cycle add included
            if (dq_queue == queue_id_t'(q)) begin
                dq_avail = cnt_q[q];
                if (enq && tbl.req_queue == queue_id_t'(q)) begin
                    dq_avail = cnt_q[q] + enq_blen;
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////
    // State
    //////////////////////////////////////////////////////////////

    always_ff @(posedge core_clk_ifc or negedge arst_n) begin
        if (!arst_n) begin
            for (int q = 0; q < NUM_QUEUES; q++) begin
                cnt_q[q] <= '0;
            end
            queue_empty <= '1;
        end else begin
            for (int q = 0; q < NUM_QUEUES; q++) begin
                cnt_q[q]       <= cnt_d[q];
                queue_empty[q] <= cnt_d[q] == '0;
            end
        end
    end

    // Scheduler only dequeues from queues that exist
    a_dq_queue_range: assert property (@(posedge core_clk_ifc) disable iff (!arst_n)
        dq_valid |-> int'(dq_queue) < NUM_QUEUES);

    // No dequeue of bytes that were never enqueued
    a_dq_no_underflow: assert property (@(posedge core_clk_ifc) disable iff (!arst_n)
        dq_valid |-> occupancy_t'(dq_blen) <= dq_avail);

endmodule

/* hdl/queue_geom_pkg.sv */
/* Queue numbering and buffer page geometry of the egress buffer,
   with the scalar types that the queue state tables are built from. */
package queue_geom_pkg;

    //////////////////////////////////////////////////////////////
    // Queue numbering
    //////////////////////////////////////////////////////////////

    // Priority queues behind every egress port
    localparam int QUEUES_PER_PORT = 4;
    // Largest port count the queue index can address
    localparam int MAX_EGR_PORTS   = 8;
    localparam int MAX_QUEUES      = MAX_EGR_PORTS * QUEUES_PER_PORT;
    localparam int QUEUE_ID_W      = $clog2(MAX_QUEUES);

    typedef logic [QUEUE_ID_W-1:0] queue_id_t;

    //////////////////////////////////////////////////////////////
    // Page geometry
    //////////////////////////////////////////////////////////////

    localparam int NUM_PAGES      = 512;
    localparam int WORDS_PER_PAGE = 64;
    localparam int BYTES_PER_WORD = 64;

    // Word offset inside a page
    typedef logic [$clog2(WORDS_PER_PAGE)-1:0] word_off_t;

    // Page number in the shared buffer
    typedef logic [$clog2(NUM_PAGES)-1:0] page_ptr_t;

    // 1 to 64 bytes, one bit wider than a byte offset
    typedef logic [$clog2(BYTES_PER_WORD):0] word_blen_t;

    // Byte occupancy of one queue
    typedef logic [31:0] occupancy_t;

endpackage

/* hdl/queue_regs_pkg.sv */
/* Bus-side word layouts of the queue state block: AXI4-Lite address,
   data and response types, and the two views of the tail pointer word. */
package queue_regs_pkg;

    localparam int A4L_ADDR_W = 8;
    localparam int A4L_DATA_W = 32;

    // Queue number field inside the byte address
    localparam int ADDR_QUEUE_LSB = 2;
    localparam int ADDR_QUEUE_MSB = 6;

    typedef logic [A4L_ADDR_W-1:0] a4l_addr_t;
    typedef logic [A4L_DATA_W-1:0] a4l_data_t;
    typedef logic [1:0]            a4l_resp_t;

    localparam a4l_resp_t RESP_OKAY   = 2'b00;
    localparam a4l_resp_t RESP_SLVERR = 2'b10;

    //////////////////////////////////////////////////////////////
    // Tail pointer word
    //////////////////////////////////////////////////////////////

    // Read view, the record as it stands
    typedef struct packed {
        logic [15:0]               rsvd;
        logic                      page_valid;
        queue_geom_pkg::page_ptr_t current_page;
        queue_geom_pkg::word_off_t tail_off;
    } tail_rd_t;

    // Write view, the update from the enqueue side
    typedef struct packed {
        logic [15:0]               rsvd;
        logic                      malloc_approved;
        queue_geom_pkg::page_ptr_t next_page;
        queue_geom_pkg::word_off_t new_tail_off;
    } tail_wr_t;

    // Same 32 bits, decoded by direction
    typedef union packed {
        tail_rd_t rd;
        tail_wr_t wr;
    } tail_word_u;

endpackage

/* hdl/queue_states_top.sv */
/* Per-queue state block of the egress buffer. Occupancy and tail pointer
   tables behind two AXI4-Lite slaves, plus the dequeue notification input. */
`timescale 1ns/1ps

module queue_states_top #(
    parameter int NUM_EGR_PORTS = 4
) (
    input  logic                       core_clk_ifc,
    input  logic                       arst_n,
    // Occupancy bus, congestion manager side
    input  logic                       occ_awvalid,
    output logic                       occ_awready,
    input  queue_regs_pkg::a4l_addr_t  occ_awaddr,
    input  logic                       occ_wvalid,
    output logic                       occ_wready,
    input  queue_regs_pkg::a4l_data_t  occ_wdata,
    output logic                       occ_bvalid,
    input  logic                       occ_bready,
    output queue_regs_pkg::a4l_resp_t  occ_bresp,
    input  logic                       occ_arvalid,
    output logic                       occ_arready,
    input  queue_regs_pkg::a4l_addr_t  occ_araddr,
    output logic                       occ_rvalid,
    input  logic                       occ_rready,
    output queue_regs_pkg::a4l_data_t  occ_rdata,
    output queue_regs_pkg::a4l_resp_t  occ_rresp,
    // Tail pointer bus, enqueue side
    input  logic                       tail_awvalid,
    output logic                       tail_awready,
    input  queue_regs_pkg::a4l_addr_t  tail_awaddr,
    input  logic                       tail_wvalid,
    output logic                       tail_wready,
    input  queue_regs_pkg::a4l_data_t  tail_wdata,
    output logic                       tail_bvalid,
    input  logic                       tail_bready,
    output queue_regs_pkg::a4l_resp_t  tail_bresp,
    input  logic                       tail_arvalid,
    output logic                       tail_arready,
    input  queue_regs_pkg::a4l_addr_t  tail_araddr,
    output logic                       tail_rvalid,
    input  logic                       tail_rready,
    output queue_regs_pkg::a4l_data_t  tail_rdata,
    output queue_regs_pkg::a4l_resp_t  tail_rresp,
    // Dequeue notifications, never back-pressured
    input  logic                       dq_valid,
    input  queue_geom_pkg::queue_id_t  dq_queue,
    input  queue_geom_pkg::word_blen_t dq_blen,
    input  logic                       dq_last,
    output logic [NUM_EGR_PORTS*queue_geom_pkg::QUEUES_PER_PORT-1:0] queue_empty
);

    import queue_geom_pkg::*;

    table_access_if occ_acc ();
    table_access_if tail_acc ();

    //////////////////////////////////////////////////////////////
    // Occupancy path
    //////////////////////////////////////////////////////////////

    a4l_table_port #(.NUM_EGR_PORTS(NUM_EGR_PORTS)) occ_port (
        .core_clk_ifc(core_clk_ifc), .arst_n(arst_n),
        .awvalid(occ_awvalid), .awready(occ_awready), .awaddr(occ_awaddr),
        .wvalid(occ_wvalid), .wready(occ_wready), .wdata(occ_wdata),
        .bvalid(occ_bvalid), .bready(occ_bready), .bresp(occ_bresp),
        .arvalid(occ_arvalid), .arready(occ_arready), .araddr(occ_araddr),
        .rvalid(occ_rvalid), .rready(occ_rready), .rdata(occ_rdata), .rresp(occ_rresp),
        .tbl(occ_acc.port_side)
    );

    occupancy_table #(.NUM_EGR_PORTS(NUM_EGR_PORTS)) occ_tbl (
        .core_clk_ifc(core_clk_ifc), .arst_n(arst_n), .tbl(occ_acc.table_side),
        .dq_valid(dq_valid), .dq_queue(dq_queue), .dq_blen(dq_blen),
        .queue_empty(queue_empty)
    );

    //////////////////////////////////////////////////////////////
    // Tail pointer path
    //////////////////////////////////////////////////////////////

    a4l_table_port #(.NUM_EGR_PORTS(NUM_EGR_PORTS)) tail_port (
        .core_clk_ifc(core_clk_ifc), .arst_n(arst_n),
        .awvalid(tail_awvalid), .awready(tail_awready), .awaddr(tail_awaddr),
        .wvalid(tail_wvalid), .wready(tail_wready), .wdata(tail_wdata),
        .bvalid(tail_bvalid), .bready(tail_bready), .bresp(tail_bresp),
        .arvalid(tail_arvalid), .arready(tail_arready), .araddr(tail_araddr),
        .rvalid(tail_rvalid), .rready(tail_rready), .rdata(tail_rdata), .rresp(tail_rresp),
        .tbl(tail_acc.port_side)
    );

    tail_pointer_table #(.NUM_EGR_PORTS(NUM_EGR_PORTS)) tail_tbl (
        .core_clk_ifc(core_clk_ifc), .arst_n(arst_n), .tbl(tail_acc.table_side)
    );

    // Every notification carries bytes, only a packet's last word may be short
    a_dq_word_len: assert property (@(posedge core_clk_ifc) disable iff (!arst_n)
        dq_valid |-> dq_blen != '0 &&
                     (dq_last || dq_blen == word_blen_t'(BYTES_PER_WORD)));

endmodule

/* hdl/table_access_if.sv */
/* Single-beat access path between an AXI4-Lite front end and one
   queue state table. One access at most per clock. */
`timescale 1ns/1ps

interface table_access_if;

    import queue_geom_pkg::*;
    import queue_regs_pkg::*;

    // Request, held for exactly the cycle of the access
    logic      req_valid;
    logic      req_write;
    queue_id_t req_queue;
    a4l_data_t req_wdata;

    // Entry at req_queue as it was before this cycle's write
    a4l_data_t rd_data;

    modport port_side (
        output req_valid,
        output req_write,
        output req_queue,
        output req_wdata,
        input  rd_data
    );

    modport table_side (
        input  req_valid,
        input  req_write,
        input  req_queue,
        input  req_wdata,
        output rd_data
    );

endinterface

/* hdl/tail_pointer_table.sv */
/* Tail record of every queue: word offset in the current page, the page
   number and its valid bit. Read and written by the enqueue side. */
`timescale 1ns/1ps

module tail_pointer_table #(
    parameter int NUM_EGR_PORTS = 4
) (
    input  logic               core_clk_ifc,
    input  logic               arst_n,
    table_access_if.table_side tbl
);

    import queue_geom_pkg::*;
    import queue_regs_pkg::*;

    localparam int NUM_QUEUES = NUM_EGR_PORTS * QUEUES_PER_PORT;

    word_off_t             tail_off_q [NUM_QUEUES];
    page_ptr_t             cur_page_q [NUM_QUEUES];
    logic [NUM_QUEUES-1:0] page_valid_q;
    tail_word_u            wr_word;
    tail_word_u            rd_word;
    logic                  upd;

    assign wr_word = tbl.req_wdata;
    assign upd     = tbl.req_valid & tbl.req_write;

    // Read word sits on the same bit positions as the write word
    always_comb begin
        rd_word = '0;
        for (int q = 0; q < NUM_QUEUES; q++) begin
            if (tbl.req_queue == queue_id_t'(q)) begin
                rd_word.rd.page_valid   = page_valid_q[q];
                rd_word.rd.current_page = cur_page_q[q];
                rd_word.rd.tail_off     = tail_off_q[q];
            end
        end
    end

    assign tbl.rd_data = rd_word;

    //////////////////////////////////////////////////////////////
    // Record update
    //////////////////////////////////////////////////////////////

    always_ff @(posedge core_clk_ifc or negedge arst_n) begin
        if (!arst_n) begin
            for (int q = 0; q < NUM_QUEUES; q++) begin
                tail_off_q[q] <= '0;
                cur_page_q[q] <= '0;
            end
            page_valid_q <= '0;
        end else if (upd) begin
            for (int q = 0; q < NUM_QUEUES; q++) begin
                if (tbl.req_queue == queue_id_t'(q)) begin
                    // Offset always moves, page only on a granted malloc
                    tail_off_q[q] <= wr_word.wr.new_tail_off;
                    if (wr_word.wr.malloc_approved) begin
                        cur_page_q[q]   <= wr_word.wr.next_page;
                        page_valid_q[q] <= 1'b1;
                    end
                end
            end
        end
    end

endmodule

/* run_sim.sh */
#!/bin/sh
# Build the queue state testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
    --top-module queue_states_tb -f vlog.f \
    -Mdir obj_dir -o queue_states_sim

./obj_dir/queue_states_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "Finished with no errors" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

/* vlog.f */
+incdir+dv
hdl/queue_geom_pkg.sv
hdl/queue_regs_pkg.sv
hdl/table_access_if.sv
hdl/a4l_table_port.sv
hdl/occupancy_table.sv
hdl/tail_pointer_table.sv
hdl/queue_states_top.sv
dv/queue_states_tb.sv
